// ==== bench/rw_stage_model.svh ====
`ifndef RW_STAGE_MODEL_SVH
`define RW_STAGE_MODEL_SVH

// Everything one accepted task should produce.
typedef struct packed {
   logic                has_write;
   rw_pkg::mem_write_t  write;
   logic                has_child;
   rw_pkg::child_task_t child;
   rw_pkg::rw_data_t    child_data;
   logic                has_finish;
   logic                is_undo;
   rw_pkg::cq_slot_t    slot;
   rw_pkg::thread_id_t  thread;
} expect_t;

rw_pkg::mem_write_t exp_writes [$];
expect_t exp_children [$];
expect_t exp_finishes [$];

// One 32-bit word placed in its lane of a 128-bit beat.
function automatic rw_pkg::mem_write_t lane_write(input rw_pkg::addr_t addr,
                                                 input rw_pkg::rw_data_t value,
                                                 input rw_pkg::thread_id_t thread);
   rw_pkg::mem_write_t w;
   int lane;
   lane = int'(addr[3:2]);
   w.waddr = addr;
   w.wdata = {96'd0, value} << (lane * 32);
   w.wstrb = 16'h000F << (lane * 4);
   w.wid = thread;
   return w;
endfunction

function automatic expect_t model_task(input rw_pkg::rw_write_t t);
   expect_t e;
   e = '0;
   e.slot = t.cq_slot;
   e.thread = t.thread;
   case (t.task_desc.op)
      rw_pkg::OP_UNDO_RESTORE: begin
         // Logged old value goes back to memory.
         e.has_write = 1'b1;
         e.write = lane_write(t.task_desc.addr, t.object, t.thread);
         e.has_finish = 1'b1;
         e.is_undo = 1'b1;
      end
      rw_pkg::OP_STORE: begin
         e.has_write = 1'b1;
         e.write = lane_write(t.task_desc.addr, t.task_desc.operand, t.thread);
         e.has_finish = 1'b1;
      end
      rw_pkg::OP_ADD: begin
         e.has_write = 1'b1;
         e.write = lane_write(t.task_desc.addr, t.object + t.task_desc.operand, t.thread);
         e.has_finish = 1'b1;
      end
      rw_pkg::OP_SPAWN: begin
         e.has_child = 1'b1;
         e.child.op = rw_pkg::OP_STORE;
         e.child.addr = t.task_desc.addr + 32'd4;
         e.child.operand = t.task_desc.operand;
         e.child.is_rw = 1'b1;
         e.child_data = t.object;
      end
      default: begin
         e.has_finish = 1'b1;
      end
   endcase
   return e;
endfunction

task automatic push_expected(input expect_t e);
   if (e.has_write) begin
      exp_writes.push_back(e.write);
   end
   if (e.has_child) begin
      exp_children.push_back(e);
   end
   if (e.has_finish) begin
      exp_finishes.push_back(e);
   end
endtask

`endif

// ==== bench/rw_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rw_stage_tb;

   localparam int N_TASKS = 200;
   localparam int CYCLE_LIMIT = 40 * N_TASKS + 200;
   localparam logic [31:0] THRESH = 32'd8;

   logic clk;
   logic rstn;
   logic task_in_valid;
   rw_pkg::rw_write_t task_in;
   logic task_in_ready;
   rw_pkg::occ_t queue_occ;
   logic gvt_slot_valid;
   rw_pkg::cq_slot_t gvt_slot;
   logic mem_wvalid;
   rw_pkg::mem_write_t mem_w;
   logic mem_wready;
   logic mem_bvalid;
   rw_pkg::thread_id_t mem_bid;
   logic mem_bready;
   logic task_out_valid;
   logic task_out_ready;
   rw_pkg::child_task_t task_out;
   rw_pkg::rw_data_t task_out_data;
   rw_pkg::cq_slot_t task_out_slot;
   rw_pkg::thread_id_t task_out_thread;
   logic finish_valid;
   logic finish_ready;
   rw_pkg::cq_slot_t finish_slot;
   logic finish_is_undo;
   logic unlock_valid;
   rw_pkg::thread_id_t unlock_thread;
   csr_pkg::csr_req_t csr_req;
   csr_pkg::csr_rsp_t csr_rsp;

   `include "rw_stage_model.svh"

   rw_pkg::rw_write_t tasks [N_TASKS];
   int issue_idx = 0;
   logic traffic_on = 1'b0;
   logic counting = 1'b0;
   rw_pkg::occ_t prog_thresh = '1;
   int cycle = 0;
   int accepted_started = 0;
   int restore_full_accepts = 0;
   int gvt_full_accepts = 0;
   logic direct_pending = 1'b0;
   rw_pkg::thread_id_t direct_expect = '0;
   // Write responses seen per thread that still wait for their unlock.
   int resp_owed [16] = '{default: 0};
   rw_pkg::thread_id_t resp_ids [$];
   int resp_due [$];
   int last_due = 0;

   rw_stage_top dut (
      .clk(clk),
      .rstn(rstn),
      .task_in_valid(task_in_valid),
      .task_in(task_in),
      .task_in_ready(task_in_ready),
      .queue_occ(queue_occ),
      .gvt_slot_valid(gvt_slot_valid),
      .gvt_slot(gvt_slot),
      .mem_wvalid(mem_wvalid),
      .mem_w(mem_w),
      .mem_wready(mem_wready),
      .mem_bvalid(mem_bvalid),
      .mem_bid(mem_bid),
      .mem_bready(mem_bready),
      .task_out_valid(task_out_valid),
      .task_out_ready(task_out_ready),
      .task_out(task_out),
      .task_out_data(task_out_data),
      .task_out_slot(task_out_slot),
      .task_out_thread(task_out_thread),
      .finish_valid(finish_valid),
      .finish_ready(finish_ready),
      .finish_slot(finish_slot),
      .finish_is_undo(finish_is_undo),
      .unlock_valid(unlock_valid),
      .unlock_thread(unlock_thread),
      .csr_req(csr_req),
      .csr_rsp(csr_rsp)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   task automatic end_in_failure();
      $display("STATUS: FAIL");
      $fatal(1, "Run stopped at cycle %0d", cycle);
   endtask

   task automatic explain_failure(input string reason);
      $display("%s", reason);
      end_in_failure();
   endtask

   task automatic check_write(input string name, input rw_pkg::mem_write_t exp,
                              input rw_pkg::mem_write_t act);
      if (act !== exp) begin
         $display("** Error: %s: expected %h, actual %h", name, exp, act);
         end_in_failure();
      end
   endtask

   task automatic check_child(input string name,
                              input rw_pkg::child_task_t exp, input rw_pkg::child_task_t act,
                              input rw_pkg::rw_data_t exp_data, input rw_pkg::rw_data_t act_data,
                              input rw_pkg::cq_slot_t exp_slot, input rw_pkg::cq_slot_t act_slot,
                              input rw_pkg::thread_id_t exp_thr,
                              input rw_pkg::thread_id_t act_thr);
      if (act !== exp || act_data !== exp_data || act_slot !== exp_slot ||
          act_thr !== exp_thr) begin
         $write("** Error: %s: expected %h data %h slot %h thread %h, ",
                name, exp, exp_data, exp_slot, exp_thr);
         $display("actual %h data %h slot %h thread %h",
                  act, act_data, act_slot, act_thr);
         end_in_failure();
      end
   endtask

   task automatic check_finish(input string name,
                               input rw_pkg::cq_slot_t exp_slot, input logic exp_undo,
                               input rw_pkg::cq_slot_t act_slot, input logic act_undo);
      if (act_slot !== exp_slot || act_undo !== exp_undo) begin
         $display("** Error: %s: expected slot %h undo %b, actual slot %h undo %b",
                  name, exp_slot, exp_undo, act_slot, act_undo);
         end_in_failure();
      end
   endtask

   task automatic check_unlock(input string name, input rw_pkg::thread_id_t exp,
                               input rw_pkg::thread_id_t act);
      if (act !== exp) begin
         $display("** Error: %s: expected thread %h, actual thread %h", name, exp, act);
         end_in_failure();
      end
   endtask

   task automatic check_csr(input string name, input csr_pkg::csr_rsp_t exp,
                            input csr_pkg::csr_rsp_t act);
      if (act !== exp) begin
         $display("** Error: %s: expected %h, actual %h", name, exp, act);
         end_in_failure();
      end
   endtask

   function automatic logic all_drained();
      int owed;
      owed = 0;
      for (int i = 0; i < 16; i++) begin
         owed += resp_owed[i];
      end
      return exp_writes.size() == 0 && exp_children.size() == 0 &&
             exp_finishes.size() == 0 && resp_ids.size() == 0 && owed == 0 &&
             !direct_pending;
   endfunction

   // Compares every handshake that completes on this rising edge.
   task automatic watch_outputs();
      expect_t e;
      int due;
      logic gvt_match;
      if (direct_pending) begin
         if (!unlock_valid) begin
            explain_failure("No unlock pulse one cycle after a task without a write");
         end
         check_unlock("direct unlock", direct_expect, unlock_thread);
      end else if (unlock_valid) begin
         if (resp_owed[unlock_thread] == 0) begin
            explain_failure($sformatf("Unlock for thread %0d without a write response",
                                      unlock_thread));
         end
         resp_owed[unlock_thread] = resp_owed[unlock_thread] - 1;
      end
      direct_pending = 1'b0;

      if (mem_wvalid && mem_wready) begin
         if (exp_writes.size() == 0) begin
            explain_failure("Memory write beat that no task asked for");
         end
         check_write("write beat", exp_writes.pop_front(), mem_w);
         // Responses stay in order, each 1 to 4 cycles after its beat.
         due = cycle + int'($urandom_range(1, 4));
         if (due < last_due) begin
            due = last_due;
         end
         last_due = due;
         resp_ids.push_back(mem_w.wid);
         resp_due.push_back(due);
      end

      if (mem_bvalid && mem_bready) begin
         resp_owed[mem_bid] = resp_owed[mem_bid] + 1;
         void'(resp_ids.pop_front());
         void'(resp_due.pop_front());
      end

      if (task_out_valid && task_out_ready) begin
         if (exp_children.size() == 0) begin
            explain_failure("Child task that no task asked for");
         end
         e = exp_children.pop_front();
         check_child("child task", e.child, task_out, e.child_data, task_out_data,
                     e.slot, task_out_slot, e.thread, task_out_thread);
      end

      if (finish_valid && finish_ready) begin
         if (exp_finishes.size() == 0) begin
            explain_failure("Finish notice that no task asked for");
         end
         e = exp_finishes.pop_front();
         check_finish("finish notice", e.slot, e.is_undo, finish_slot, finish_is_undo);
      end

      if (task_in_valid && task_in_ready) begin
         e = model_task(task_in);
         push_expected(e);
         if (!e.has_write) begin
            direct_pending = 1'b1;
            direct_expect = task_in.thread;
         end
         gvt_match = gvt_slot_valid && (gvt_slot == task_in.cq_slot);
         if (queue_occ >= prog_thresh) begin
            if (task_in.task_desc.op == rw_pkg::OP_UNDO_RESTORE) begin
               restore_full_accepts++;
            end else if (!gvt_match) begin
               explain_failure("Task accepted while the task queue was at its threshold");
            end else begin
               gvt_full_accepts++;
            end
         end
         if (counting) begin
            accepted_started++;
         end
         issue_idx++;
      end
   endtask

   always @(posedge clk) begin
      cycle = cycle + 1;
      if (cycle >= CYCLE_LIMIT) begin
         $display("Timeout: the run hung with %0d of %0d tasks accepted", issue_idx, N_TASKS);
         end_in_failure();
      end else if (rstn) begin
         watch_outputs();
      end
   end

   // Random responders and the task source, all on the falling edge.
   initial begin
      task_in_valid = 1'b0;
      task_in = '0;
      queue_occ = '0;
      gvt_slot_valid = 1'b0;
      gvt_slot = '0;
      mem_wready = 1'b0;
      mem_bvalid = 1'b0;
      mem_bid = '0;
      task_out_ready = 1'b0;
      finish_ready = 1'b0;
      forever begin
         @(negedge clk);
         mem_wready = ($urandom_range(0, 3) != 0);
         task_out_ready = ($urandom_range(0, 3) != 0);
         finish_ready = ($urandom_range(0, 3) != 0);
         queue_occ = rw_pkg::occ_t'($urandom_range(0, 15));
         if (traffic_on && issue_idx < N_TASKS) begin
            task_in_valid = 1'b1;
            task_in = tasks[issue_idx];
         end else begin
            task_in_valid = 1'b0;
         end
         gvt_slot_valid = ($urandom_range(0, 1) != 0);
         if ($urandom_range(0, 1) != 0) begin
            gvt_slot = task_in.cq_slot;
         end else begin
            gvt_slot = rw_pkg::cq_slot_t'($urandom);
         end
         if (resp_ids.size() > 0 && resp_due[0] <= cycle) begin
            mem_bvalid = 1'b1;
            mem_bid = resp_ids[0];
         end else begin
            mem_bvalid = 1'b0;
         end
      end
   end

   task automatic write_register(input logic [7:0] addr, input logic [31:0] data);
      @(negedge clk);
      csr_req.wvalid = 1'b1;
      csr_req.waddr = addr;
      csr_req.wdata = data;
      @(negedge clk);
      csr_req.wvalid = 1'b0;
   endtask

   task automatic read_and_compare(input string name, input logic [7:0] addr,
                                   input logic [31:0] data);
      csr_pkg::csr_rsp_t exp;
      exp.rvalid = 1'b1;
      exp.rdata = data;
      @(negedge clk);
      csr_req.arvalid = 1'b1;
      csr_req.araddr = addr;
      @(negedge clk);
      csr_req.arvalid = 1'b0;
      check_csr(name, exp, csr_rsp);
      @(negedge clk);
      if (csr_rsp.rvalid) begin
         explain_failure("Register read response stayed valid for more than one cycle");
      end
   endtask

   initial begin
      rstn = 1'b0;
      csr_req = '0;
      void'($urandom(93035));
      for (int i = 0; i < N_TASKS; i++) begin
         tasks[i].task_desc.op = rw_pkg::task_op_e'(3'($urandom_range(0, 4)));
         tasks[i].task_desc.addr = $urandom & 32'hFFFF_FFFC;
         tasks[i].task_desc.operand = $urandom;
         tasks[i].object = $urandom;
         tasks[i].cq_slot = rw_pkg::cq_slot_t'($urandom);
         tasks[i].thread = rw_pkg::thread_id_t'($urandom);
      end
      repeat (2) @(negedge clk);
      rstn = 1'b1;

      read_and_compare("threshold after reset", csr_pkg::CSR_QUEUE_THRESH, 32'h0000_00FF);
      write_register(csr_pkg::CSR_QUEUE_THRESH, THRESH);
      prog_thresh = THRESH[7:0];
      read_and_compare("threshold readback", csr_pkg::CSR_QUEUE_THRESH, THRESH);
      write_register(csr_pkg::CSR_START, 32'd1);
      counting = 1'b1;

      @(posedge clk);
      traffic_on = 1'b1;
      while (issue_idx < N_TASKS) begin
         @(negedge clk);
      end
      while (!all_drained()) begin
         @(negedge clk);
      end

      write_register(csr_pkg::CSR_START, 32'd0);
      counting = 1'b0;
      read_and_compare("processed count", csr_pkg::CNT_PROCESSED, accepted_started);

      // Quiet window to catch late or duplicated results.
      repeat (10) @(negedge clk);
      if (!all_drained()) begin
         explain_failure("Expected results still outstanding at the end of the run");
      end else if (restore_full_accepts == 0) begin
         explain_failure("No restore task was accepted with the task queue at its threshold");
      end else if (gvt_full_accepts == 0) begin
         explain_failure("No GVT task was accepted with the task queue at its threshold");
      end else begin
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the testbench with Verilator; exit status is the result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module rw_stage_tb \
   -f sim.f \
   -o rw_stage_sim

./obj_dir/rw_stage_sim

// ==== sim.f ====
+incdir+bench
source/rw_pkg.sv
source/csr_pkg.sv
source/sync_fifo.sv
source/rw_worker.sv
source/mem_write_port.sv
source/rw_write_stage.sv
source/stage_csr.sv
source/rw_stage_top.sv
bench/rw_stage_tb.sv

// ==== source/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

   typedef struct packed {
      logic        wvalid;
      logic [7:0]  waddr;
      logic [31:0] wdata;
      logic        arvalid;
      logic [7:0]  araddr;
   } csr_req_t;

   typedef struct packed {
      logic        rvalid;
      logic [31:0] rdata;
   } csr_rsp_t;

   // Configuration registers.
   localparam logic [7:0] CSR_START        = 8'h00;
   localparam logic [7:0] CSR_QUEUE_THRESH = 8'h04;
   localparam logic [7:0] CSR_QUEUE_OCC    = 8'h08;

   // Read-only stall-cause cycle counters.
   localparam logic [7:0] CNT_IDLE         = 8'h80;
   localparam logic [7:0] CNT_PROCESSED    = 8'h84;
   localparam logic [7:0] CNT_QUEUE_FULL   = 8'h88;
   localparam logic [7:0] CNT_MEM          = 8'h8C;
   localparam logic [7:0] CNT_FINISH       = 8'h90;
   localparam logic [7:0] CNT_OTHER        = 8'hA0;

endpackage

`default_nettype wire

// ==== source/mem_write_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_write_port (
   input  logic                 clk,
   input  logic                 rstn,

   input  logic                 wr_valid,
   input  rw_pkg::write_req_t   wr_req,
   output logic                 wr_ready,

   output logic                 mem_wvalid,
   output rw_pkg::mem_write_t   mem_w,
   input  logic                 mem_wready,
   input  logic                 mem_bvalid,
   input  rw_pkg::thread_id_t   mem_bid,
   output logic                 mem_bready,

   input  logic                 direct_unlock,
   input  rw_pkg::thread_id_t   direct_thread,
   output logic                 unlock_valid,
   output rw_pkg::thread_id_t   unlock_thread
);

   rw_pkg::write_req_t head;
   logic wfifo_full;
   logic wfifo_empty;
   rw_pkg::thread_id_t bid_head;
   logic bfifo_full;
   logic bfifo_empty;
   logic bpop;
   logic [$clog2(rw_pkg::LANES)-1:0] lane;

   sync_fifo #(
      .WIDTH($bits(rw_pkg::write_req_t)),
      .LOG_DEPTH(rw_pkg::FIFO_LOG_DEPTH)
   ) wdata_fifo (
      .clk(clk),
      .rstn(rstn),
      .wr_en(wr_valid),
      .wr_data(wr_req),
      .rd_en(mem_wvalid & mem_wready),
      .rd_data(head),
      .full(wfifo_full),
      .empty(wfifo_empty)
   );

   sync_fifo #(
      .WIDTH($bits(rw_pkg::thread_id_t)),
      .LOG_DEPTH(rw_pkg::FIFO_LOG_DEPTH)
   ) bresp_fifo (
      .clk(clk),
      .rstn(rstn),
      .wr_en(mem_bvalid & mem_bready),
      .wr_data(mem_bid),
      .rd_en(bpop),
      .rd_data(bid_head),
      .full(bfifo_full),
      .empty(bfifo_empty)
   );

   assign wr_ready = !wfifo_full;
   assign mem_wvalid = !wfifo_empty;
   assign mem_bready = !bfifo_full;
   assign lane = head.addr[3:2];

   // Only the addressed lane carries data and strobes.
   always_comb begin
      mem_w = '0;
      mem_w.waddr = head.addr;
      mem_w.wid = head.thread;
      mem_w.wdata[lane*32 +: 32] = head.data;
      mem_w.wstrb[lane*4 +: 4] = 4'hF;
   end

   // A no-write unlock from the stage wins the slot this cycle.
   assign bpop = !bfifo_empty && !direct_unlock;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         unlock_valid <= 1'b0;
      end else begin
         unlock_valid <= direct_unlock || !bfifo_empty;
      end
   end

   always_ff @(posedge clk) begin
      if (direct_unlock) begin
         unlock_thread <= direct_thread;
      end else if (!bfifo_empty) begin
         unlock_thread <= bid_head;
      end
   end

   a_beat_held: assert property (@(posedge clk) disable iff (!rstn)
      mem_wvalid && !mem_wready |=> mem_wvalid && $stable(mem_w));

endmodule

`default_nettype wire

// ==== source/rw_pkg.sv ====
`default_nettype none

package rw_pkg;

   // Four 32-bit lanes per memory beat.
   localparam int LANES = 4;
   localparam int FIFO_LOG_DEPTH = 1;

   typedef enum logic [2:0] {
      OP_STORE        = 3'd0,
      OP_ADD          = 3'd1,
      OP_SPAWN        = 3'd2,
      OP_READ         = 3'd3,
      OP_UNDO_RESTORE = 3'd4
   } task_op_e;

   typedef logic [31:0] rw_data_t;
   // Bits [3:2] of a byte address pick the lane.
   typedef logic [31:0] addr_t;
   typedef logic [3:0]  thread_id_t;
   typedef logic [5:0]  cq_slot_t;
   typedef logic [7:0]  occ_t;

   typedef struct packed {
      task_op_e op;
      addr_t    addr;
      rw_data_t operand;
   } task_desc_t;

   typedef struct packed {
      task_desc_t task_desc;
      rw_data_t   object;
      cq_slot_t   cq_slot;
      thread_id_t thread;
   } rw_write_t;

   typedef struct packed {
      task_op_e op;
      addr_t    addr;
      rw_data_t operand;
      logic     is_rw;
   } child_task_t;

   typedef struct packed {
      addr_t                 waddr;
      logic [LANES*32-1:0]   wdata;
      logic [LANES*4-1:0]    wstrb;
      thread_id_t            wid;
   } mem_write_t;

   typedef struct packed {
      addr_t      addr;
      rw_data_t   data;
      thread_id_t thread;
   } write_req_t;

   typedef enum logic [2:0] {
      ST_IDLE       = 3'd0,
      ST_PROCESSED  = 3'd1,
      ST_QUEUE_FULL = 3'd2,
      ST_MEM        = 3'd3,
      ST_FINISH     = 3'd4,
      ST_OTHER      = 3'd5
   } stall_e;

endpackage

`default_nettype wire

// ==== source/rw_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rw_stage_top (
   input  logic                 clk,
   input  logic                 rstn,

   input  logic                 task_in_valid,
   input  rw_pkg::rw_write_t    task_in,
   output logic                 task_in_ready,

   input  rw_pkg::occ_t         queue_occ,
   input  logic                 gvt_slot_valid,
   input  rw_pkg::cq_slot_t     gvt_slot,

   output logic                 mem_wvalid,
   output rw_pkg::mem_write_t   mem_w,
   input  logic                 mem_wready,
   input  logic                 mem_bvalid,
   input  rw_pkg::thread_id_t   mem_bid,
   output logic                 mem_bready,

   output logic                 task_out_valid,
   input  logic                 task_out_ready,
   output rw_pkg::child_task_t  task_out,
   output rw_pkg::rw_data_t     task_out_data,
   output rw_pkg::cq_slot_t     task_out_slot,
   output rw_pkg::thread_id_t   task_out_thread,

   output logic                 finish_valid,
   input  logic                 finish_ready,
   output rw_pkg::cq_slot_t     finish_slot,
   output logic                 finish_is_undo,

   output logic                 unlock_valid,
   output rw_pkg::thread_id_t   unlock_thread,

   input  csr_pkg::csr_req_t    csr_req,
   output csr_pkg::csr_rsp_t    csr_rsp
);

   logic wr_valid;
   rw_pkg::write_req_t wr_req;
   logic wr_ready;
   logic direct_unlock;
   rw_pkg::thread_id_t direct_thread;
   rw_pkg::occ_t queue_thresh;
   rw_pkg::stall_e stall;

   rw_write_stage stage (
      .clk(clk),
      .rstn(rstn),
      .task_in_valid(task_in_valid),
      .task_in(task_in),
      .task_in_ready(task_in_ready),
      .queue_occ(queue_occ),
      .queue_thresh(queue_thresh),
      .gvt_slot_valid(gvt_slot_valid),
      .gvt_slot(gvt_slot),
      .wr_valid(wr_valid),
      .wr_req(wr_req),
      .wr_ready(wr_ready),
      .direct_unlock(direct_unlock),
      .direct_thread(direct_thread),
      .task_out_valid(task_out_valid),
      .task_out_ready(task_out_ready),
      .task_out(task_out),
      .task_out_data(task_out_data),
      .task_out_slot(task_out_slot),
      .task_out_thread(task_out_thread),
      .finish_valid(finish_valid),
      .finish_ready(finish_ready),
      .finish_slot(finish_slot),
      .finish_is_undo(finish_is_undo),
      .stall(stall)
   );

   mem_write_port mem_port (
      .clk(clk),
      .rstn(rstn),
      .wr_valid(wr_valid),
      .wr_req(wr_req),
      .wr_ready(wr_ready),
      .mem_wvalid(mem_wvalid),
      .mem_w(mem_w),
      .mem_wready(mem_wready),
      .mem_bvalid(mem_bvalid),
      .mem_bid(mem_bid),
      .mem_bready(mem_bready),
      .direct_unlock(direct_unlock),
      .direct_thread(direct_thread),
      .unlock_valid(unlock_valid),
      .unlock_thread(unlock_thread)
   );

   stage_csr csr (
      .clk(clk),
      .rstn(rstn),
      .req(csr_req),
      .rsp(csr_rsp),
      .stall(stall),
      .queue_occ(queue_occ),
      .queue_thresh(queue_thresh)
   );

endmodule

`default_nettype wire

// ==== source/rw_worker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rw_worker (
   input  rw_pkg::task_desc_t  task_desc,
   input  rw_pkg::rw_data_t    object,
   output logic                wr_en,
   output rw_pkg::addr_t       wr_addr,
   output rw_pkg::rw_data_t    wr_data,
   output logic                spawn,
   output rw_pkg::child_task_t child,
   output rw_pkg::rw_data_t    child_data
);

   always_comb begin
      wr_en = 1'b0;
      wr_addr = task_desc.addr;
      wr_data = task_desc.operand;
      spawn = 1'b0;
      // Child is a store to the next word.
      child.op = rw_pkg::OP_STORE;
      child.addr = task_desc.addr + 32'd4;
      child.operand = task_desc.operand;
      child.is_rw = 1'b1;
      // Parent's object value rides along with the child.
      child_data = object;

      case (task_desc.op)
         rw_pkg::OP_STORE: begin
            wr_en = 1'b1;
         end
         rw_pkg::OP_ADD: begin
            wr_en = 1'b1;
            wr_data = object + task_desc.operand;
         end
         rw_pkg::OP_SPAWN: begin
            spawn = 1'b1;
         end
         default: begin
            // Read and anything else just finish.
            wr_en = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== source/rw_write_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module rw_write_stage (
   input  logic                 clk,
   input  logic                 rstn,

   input  logic                 task_in_valid,
   input  rw_pkg::rw_write_t    task_in,
   output logic                 task_in_ready,

   input  rw_pkg::occ_t         queue_occ,
   input  rw_pkg::occ_t         queue_thresh,
   input  logic                 gvt_slot_valid,
   input  rw_pkg::cq_slot_t     gvt_slot,

   output logic                 wr_valid,
   output rw_pkg::write_req_t   wr_req,
   input  logic                 wr_ready,

   output logic                 direct_unlock,
   output rw_pkg::thread_id_t   direct_thread,

   output logic                 task_out_valid,
   input  logic                 task_out_ready,
   output rw_pkg::child_task_t  task_out,
   output rw_pkg::rw_data_t     task_out_data,
   output rw_pkg::cq_slot_t     task_out_slot,
   output rw_pkg::thread_id_t   task_out_thread,

   output logic                 finish_valid,
   input  logic                 finish_ready,
   output rw_pkg::cq_slot_t     finish_slot,
   output logic                 finish_is_undo,

   output rw_pkg::stall_e       stall
);

   logic w_wr_en;
   rw_pkg::addr_t w_addr;
   rw_pkg::rw_data_t w_data;
   logic w_spawn;
   rw_pkg::child_task_t w_child;
   rw_pkg::rw_data_t w_child_data;

   logic is_restore;
   logic eligible;
   logic need_write;
   logic need_out;
   logic need_finish;
   logic out_room;
   logic room;
   logic accept;
   logic fin_full;
   logic fin_empty;
   logic [$bits(rw_pkg::cq_slot_t):0] fin_head;

   rw_worker worker (
      .task_desc(task_in.task_desc),
      .object(task_in.object),
      .wr_en(w_wr_en),
      .wr_addr(w_addr),
      .wr_data(w_data),
      .spawn(w_spawn),
      .child(w_child),
      .child_data(w_child_data)
   );

   assign is_restore = (task_in.task_desc.op == rw_pkg::OP_UNDO_RESTORE);

   // The GVT task is never held back by a full downstream queue.
   assign eligible = (queue_occ < queue_thresh) ||
                     (gvt_slot_valid && (gvt_slot == task_in.cq_slot));

   assign need_write = is_restore || w_wr_en;
   assign need_out = !is_restore && w_spawn;
   assign need_finish = is_restore || !w_spawn;

   assign out_room = !task_out_valid || task_out_ready;
   assign room = (!need_write || wr_ready) &&
                 (!need_out || out_room) &&
                 (!need_finish || !fin_full);

   assign task_in_ready = (is_restore || eligible) && room;
   assign accept = task_in_valid && task_in_ready;

   // A restore writes the logged value back.
   assign wr_valid = accept && need_write;
   always_comb begin
      wr_req.addr = w_addr;
      if (is_restore) begin
         wr_req.data = task_in.object;
      end else begin
         wr_req.data = w_data;
      end
      wr_req.thread = task_in.thread;
   end

   assign direct_unlock = accept && !need_write;
   assign direct_thread = task_in.thread;

   // Child task output register.
   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_out_valid <= 1'b0;
      end else if (accept && need_out) begin
         task_out_valid <= 1'b1;
      end else if (task_out_ready) begin
         task_out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept && need_out) begin
         task_out <= w_child;
         task_out_data <= w_child_data;
         task_out_slot <= task_in.cq_slot;
         task_out_thread <= task_in.thread;
      end
   end

   sync_fifo #(
      .WIDTH($bits(rw_pkg::cq_slot_t) + 1),
      .LOG_DEPTH(rw_pkg::FIFO_LOG_DEPTH)
   ) finish_fifo (
      .clk(clk),
      .rstn(rstn),
      .wr_en(accept && need_finish),
      .wr_data({task_in.cq_slot, is_restore}),
      .rd_en(finish_valid && finish_ready),
      .rd_data(fin_head),
      .full(fin_full),
      .empty(fin_empty)
   );

   assign finish_valid = !fin_empty;
   assign finish_slot = fin_head[$bits(rw_pkg::cq_slot_t):1];
   assign finish_is_undo = fin_head[0];

   // First matching cause wins.
   always_comb begin
      if (!task_in_valid) begin
         stall = rw_pkg::ST_IDLE;
      end else if (task_in_ready) begin
         stall = rw_pkg::ST_PROCESSED;
      end else if (!is_restore && !eligible) begin
         stall = rw_pkg::ST_QUEUE_FULL;
      end else if (need_write && !wr_ready) begin
         stall = rw_pkg::ST_MEM;
      end else if (need_finish && fin_full) begin
         stall = rw_pkg::ST_FINISH;
      end else begin
         stall = rw_pkg::ST_OTHER;
      end
   end

   a_child_held: assert property (@(posedge clk) disable iff (!rstn)
      task_out_valid && !task_out_ready |=> task_out_valid && $stable(task_out));

endmodule

`default_nettype wire

// ==== source/stage_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_csr (
   input  logic              clk,
   input  logic              rstn,
   input  csr_pkg::csr_req_t req,
   output csr_pkg::csr_rsp_t rsp,
   input  rw_pkg::stall_e    stall,
   input  rw_pkg::occ_t      queue_occ,
   output rw_pkg::occ_t      queue_thresh
);

   logic started;
   // One counter per stall cause, indexed by the enum value.
   logic [31:0] cnt [6];
   logic rvalid_q;
   logic [31:0] rdata_q;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         started <= 1'b0;
         queue_thresh <= '1;
      end else if (req.wvalid) begin
         case (req.waddr)
            csr_pkg::CSR_START: started <= req.wdata[0];
            csr_pkg::CSR_QUEUE_THRESH: queue_thresh <= req.wdata[7:0];
            default: started <= started;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < 6; i++) begin
            cnt[i] <= '0;
         end
      end else if (started) begin
         cnt[stall] <= cnt[stall] + 32'd1;
      end
   end

   // Read data is valid one cycle after arvalid.
   always_ff @(posedge clk) begin
      if (!rstn) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= req.arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (req.arvalid) begin
         case (req.araddr)
            csr_pkg::CSR_START: rdata_q <= {31'd0, started};
            csr_pkg::CSR_QUEUE_THRESH: rdata_q <= {24'd0, queue_thresh};
            csr_pkg::CSR_QUEUE_OCC: rdata_q <= {24'd0, queue_occ};
            csr_pkg::CNT_IDLE: rdata_q <= cnt[rw_pkg::ST_IDLE];
            csr_pkg::CNT_PROCESSED: rdata_q <= cnt[rw_pkg::ST_PROCESSED];
            csr_pkg::CNT_QUEUE_FULL: rdata_q <= cnt[rw_pkg::ST_QUEUE_FULL];
            csr_pkg::CNT_MEM: rdata_q <= cnt[rw_pkg::ST_MEM];
            csr_pkg::CNT_FINISH: rdata_q <= cnt[rw_pkg::ST_FINISH];
            csr_pkg::CNT_OTHER: rdata_q <= cnt[rw_pkg::ST_OTHER];
            default: rdata_q <= '0;
         endcase
      end
   end

   assign rsp.rvalid = rvalid_q;
   assign rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== source/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
   parameter int WIDTH = 8,
   parameter int LOG_DEPTH = 1
) (
   input  logic             clk,
   input  logic             rstn,
   input  logic             wr_en,
   input  logic [WIDTH-1:0] wr_data,
   input  logic             rd_en,
   output logic [WIDTH-1:0] rd_data,
   output logic             full,
   output logic             empty
);

   logic [WIDTH-1:0] mem [2**LOG_DEPTH];
   // One extra pointer bit tells full from empty.
   logic [LOG_DEPTH:0] wr_ptr;
   logic [LOG_DEPTH:0] rd_ptr;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr[LOG_DEPTH-1:0]] <= wr_data;
      end
   end

   assign rd_data = mem[rd_ptr[LOG_DEPTH-1:0]];
   assign empty = (wr_ptr == rd_ptr);
   assign full = (wr_ptr[LOG_DEPTH] != rd_ptr[LOG_DEPTH]) &&
                 (wr_ptr[LOG_DEPTH-1:0] == rd_ptr[LOG_DEPTH-1:0]);

   // Callers must honour the flags.
   a_no_overflow: assert property (@(posedge clk) disable iff (!rstn) wr_en |-> !full);
   a_no_underflow: assert property (@(posedge clk) disable iff (!rstn) rd_en |-> !empty);

endmodule

`default_nettype wire
